// ==== tb.f ====
flit_arb_pkg.sv
var_prio_enc.sv
lock_rr_arb.sv
flit_in_queue.sv
flit_out_stage.sv
flit_port_top.sv
tb_flit_port.sv

// ==== Bender.yml ====
package:
  name: flit_port

sources:
  - files:
      - flit_arb_pkg.sv
      - var_prio_enc.sv
      - lock_rr_arb.sv
      - flit_in_queue.sv
      - flit_out_stage.sv
      - flit_port_top.sv
  - target: test
    files:
      - tb_flit_port.sv

// ==== tb_flit_port.sv ====
// testbench for flit_port_top; runs a table of packet phases, checks order, payloads and credits
module tb_flit_port;

    import flit_arb_pkg::*;

    localparam int NUM_SRC     = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 3;
    localparam int NUM_PHASES  = 6;
    // cycles with downstream returns held off in a hold phase
    localparam int HOLD_CYC    = 16;
    // downstream credit return modes
    localparam int RTN_IMM     = 0;
    localparam int RTN_RAND    = 1;
    localparam int RTN_HOLD    = 2;

    // ------------------------------------------------------------------------
    // phase table
    // ------------------------------------------------------------------------

    // packet length per source where 0 means no packet
    int tbl_len [NUM_PHASES][NUM_SRC] = '{
        '{3, 2, 4, 1},
        '{0, 0, 1, 0},
        '{2, 0, 5, 3},
        '{6, 1, 0, 2},
        '{1, 1, 1, 1},
        '{8, 0, 0, 7}
    };
    // how downstream hands credits back in each phase
    int tbl_mode [NUM_PHASES] = '{RTN_IMM, RTN_IMM, RTN_RAND, RTN_HOLD, RTN_RAND, RTN_RAND};

    // DUT signals
    logic               clk;
    logic               i_arst_n;
    logic [NUM_SRC-1:0] i_push;
    flit_t              src_flit [NUM_SRC];
    logic [NUM_SRC-1:0] o_src_crd;
    logic               i_crd_rtn;
    logic               o_out_vld;
    flit_t              o_out_flit;

    // source models
    int       cur_len [NUM_SRC];
    int       sent_cnt [NUM_SRC];
    int       src_crd [NUM_SRC];
    int       crd_pulses [NUM_SRC];
    payload_t pay [NUM_SRC][16];

    // downstream model and expected order
    flit_t exp_q [$];
    int    rtn_due [$];
    int    last_due;
    int    received;
    int    returned;
    bit    hold;
    int    mode;
    int    pkt_src;
    bit    in_pkt;

    // bookkeeping
    int cyc;
    int model_head;
    int errors;
    int checks;
    int total_flits;

    flit_port_top #(
        .NUM_SRC     (NUM_SRC),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut0 (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_push     (i_push),
        .i_flit     (src_flit),
        .o_src_crd  (o_src_crd),
        .i_crd_rtn  (i_crd_rtn),
        .o_out_vld  (o_out_vld),
        .o_out_flit (o_out_flit)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------

    task automatic check_flit(input flit_t got, input flit_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: flit payload %h tail %b, expected payload %h tail %b",
                     $time, got.payload, got.tail, exp.payload, exp.tail);
        end
    endtask

    task automatic check_count(input crd_cnt_t got, input crd_cnt_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // nothing may leave the port before a flit was pushed
    task automatic outputs_quiet();
        checks++;
        if (o_out_vld !== 1'b0 || o_src_crd !== '0)
        begin
            errors++;
            $display("mismatch at %0t: out_vld %b src_crd %b, expected both low",
                     $time, o_out_vld, o_src_crd);
        end
    endtask

    // ------------------------------------------------------------------------
    // per-cycle models
    // ------------------------------------------------------------------------

    // observe outputs at the falling edge where they are stable
    task automatic sample_outputs();
        int    src;
        int    delay;
        int    due;
        flit_t exp_flit;
        for (int s = 0; s < NUM_SRC; s++)
        begin
            if (o_src_crd[s])
            begin
                crd_pulses[s]++;
                src_crd[s]++;
                if (src_crd[s] > QUEUE_DEPTH)
                begin
                    errors++;
                    $display("source %0d got a credit back while holding all of them at %0t",
                             s, $time);
                end
            end
        end
        if (o_out_vld)
        begin
            received++;
            if (received - returned > OUT_CREDITS)
            begin
                errors++;
                $display("more than %0d flits in flight downstream at %0t", OUT_CREDITS, $time);
            end
            // source id sits in the top payload bits
            src = int'(o_out_flit.payload[15:14]);
            if (in_pkt && src != pkt_src)
            begin
                errors++;
                $display("flit of source %0d cut into the packet of source %0d at %0t",
                         src, pkt_src, $time);
            end
            pkt_src = src;
            in_pkt  = !o_out_flit.tail;
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("a flit came out while none was expected at %0t", $time);
            end
            else
            begin
                exp_flit = exp_q.pop_front();
                check_flit(o_out_flit, exp_flit);
            end
            // earliest return is the next cycle
            delay = (mode == RTN_RAND) ? int'($urandom_range(3, 0)) : 0;
            due   = cyc + 1 + delay;
            if (due < last_due)
            begin
                due = last_due;
            end
            last_due = due;
            rtn_due.push_back(due);
        end
    endtask

    task automatic run_cycle();
        @(posedge clk);
        #2;
        cyc++;
        // sources push while they hold credit
        for (int s = 0; s < NUM_SRC; s++)
        begin
            i_push[s] = 1'b0;
            if (sent_cnt[s] < cur_len[s] && src_crd[s] > 0)
            begin
                i_push[s]           = 1'b1;
                src_flit[s].payload = pay[s][sent_cnt[s]];
                src_flit[s].tail    = (sent_cnt[s] == cur_len[s] - 1);
                src_crd[s]--;
                sent_cnt[s]++;
            end
        end
        // at most one credit back per cycle
        i_crd_rtn = 1'b0;
        if (!hold && rtn_due.size() > 0 && rtn_due[0] <= cyc)
        begin
            i_crd_rtn = 1'b1;
            void'(rtn_due.pop_front());
            returned++;
        end
        @(negedge clk);
        sample_outputs();
    endtask

    function automatic bit phase_done();
        for (int s = 0; s < NUM_SRC; s++)
        begin
            if (sent_cnt[s] < cur_len[s])
            begin
                return 1'b0;
            end
        end
        return (exp_q.size() == 0 && rtn_due.size() == 0 && !hold);
    endfunction

    // ------------------------------------------------------------------------
    // phase sequencing
    // ------------------------------------------------------------------------

    task automatic run_phase(input int p);
        int    total;
        int    last_src;
        int    k;
        int    err0;
        flit_t fl;
        total    = 0;
        last_src = -1;
        err0     = errors;
        for (int s = 0; s < NUM_SRC; s++)
        begin
            cur_len[s]    = tbl_len[p][s];
            sent_cnt[s]   = 0;
            crd_pulses[s] = 0;
            total        += cur_len[s];
            // payload is source, packet, flit number and a random nibble
            for (int f = 0; f < cur_len[s]; f++)
            begin
                pay[s][f] = {2'(s), 6'(p), 4'(f), 4'($urandom)};
            end
        end
        // packet order follows the round-robin head
        for (int i = 0; i < NUM_SRC; i++)
        begin
            k = (model_head + i) % NUM_SRC;
            for (int f = 0; f < cur_len[k]; f++)
            begin
                fl.payload = pay[k][f];
                fl.tail    = (f == cur_len[k] - 1);
                exp_q.push_back(fl);
                last_src = k;
            end
        end
        if (last_src >= 0)
        begin
            model_head = (last_src + 1) % NUM_SRC;
        end
        received = 0;
        returned = 0;
        mode     = tbl_mode[p];
        hold     = (mode == RTN_HOLD);
        in_pkt   = 1'b0;
        k        = 0;
        while (!phase_done())
        begin
            run_cycle();
            k++;
            // output must stall once the starting credits are spent
            if (hold && k == HOLD_CYC)
            begin
                check_count(crd_cnt_t'(received),
                            crd_cnt_t'((total < OUT_CREDITS) ? total : OUT_CREDITS),
                            "flits out with returns held");
                hold = 1'b0;
            end
        end
        // last return reaches the counter
        run_cycle();
        for (int s = 0; s < NUM_SRC; s++)
        begin
            check_count(crd_cnt_t'(crd_pulses[s]), crd_cnt_t'(cur_len[s]), "credit pulses");
            check_count(crd_cnt_t'(src_crd[s]), crd_cnt_t'(QUEUE_DEPTH), "source credits");
        end
        total_flits += total;
        $display("phase %0d: %0d flits, return mode %0d, %s",
                 p, total, mode, (errors == err0) ? "ok" : "errors");
    endtask

    function automatic int watchdog_cycles();
        int sum;
        int flits;
        sum = 0;
        for (int p = 0; p < NUM_PHASES; p++)
        begin
            flits = 0;
            for (int s = 0; s < NUM_SRC; s++)
            begin
                flits += tbl_len[p][s];
            end
            sum += (flits + 20) * 4;
        end
        return sum;
    endfunction

    // watchdog with a margin for reset and the idle cycles
    initial
    begin
        int limit;
        limit = watchdog_cycles() + 20;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        void'($urandom(29));
        clk         = 1'b0;
        i_arst_n    = 1'b0;
        i_push      = '0;
        i_crd_rtn   = 1'b0;
        cyc         = 0;
        model_head  = 0;
        errors      = 0;
        checks      = 0;
        total_flits = 0;
        last_due    = 0;
        received    = 0;
        returned    = 0;
        hold        = 1'b0;
        mode        = RTN_IMM;
        in_pkt      = 1'b0;
        pkt_src     = 0;
        for (int s = 0; s < NUM_SRC; s++)
        begin
            src_flit[s]   = '0;
            cur_len[s]    = 0;
            sent_cnt[s]   = 0;
            src_crd[s]    = QUEUE_DEPTH;
            crd_pulses[s] = 0;
        end
        // outputs stay low throughout reset
        repeat (8)
        begin
            @(negedge clk);
            outputs_quiet();
        end
        @(posedge clk);
        #2;
        i_arst_n = 1'b1;
        // no activity while idle after reset
        repeat (3)
        begin
            run_cycle();
            outputs_quiet();
        end
        for (int p = 0; p < NUM_PHASES; p++)
        begin
            run_phase(p);
        end
        $display("checks %0d, errors %0d, flits %0d", checks, errors, total_flits);
        if (errors == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_flit_port

// ==== flit_port_top.sv ====
// one output port of the flit switch; NUM_SRC credit-fed queues arbitrated per packet
module flit_port_top #(
    parameter int NUM_SRC     = 4,
    parameter int SRC_IDX_W   = $clog2(NUM_SRC),
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 3
) (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic [NUM_SRC-1:0]  i_push,
    input  flit_arb_pkg::flit_t i_flit [NUM_SRC],
    output logic [NUM_SRC-1:0]  o_src_crd,
    input  logic                i_crd_rtn,
    output logic                o_out_vld,
    output flit_arb_pkg::flit_t o_out_flit
);

    import flit_arb_pkg::*;

    // queue heads and status
    flit_t                q_head_flit [NUM_SRC];
    logic [NUM_SRC-1:0]   q_not_empty;
    logic [NUM_SRC-1:0]   q_tail;
    logic [NUM_SRC-1:0]   q_pop;

    // arbiter results
    logic [NUM_SRC-1:0]   gnt;
    logic [SRC_IDX_W-1:0] gnt_idx;
    logic                 gnt_vld;

    // handshake with the output stage
    flit_t                sel_flit;
    logic                 accept;
    logic                 send;

    // ------------------------------------------------------------------------
    // input queues
    // ------------------------------------------------------------------------

    for (genvar g = 0; g < NUM_SRC; g++)
    begin : g_queue
        flit_in_queue #(
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) u_queue (
            .clk         (clk),
            .i_arst_n    (i_arst_n),
            .i_push      (i_push[g]),
            .i_flit      (i_flit[g]),
            .i_pop       (q_pop[g]),
            .o_head      (q_head_flit[g]),
            .o_not_empty (q_not_empty[g]),
            .o_src_crd   (o_src_crd[g])
        );
        assign q_tail[g] = q_head_flit[g].tail;
    end

    // ------------------------------------------------------------------------
    // arbitration and output
    // ------------------------------------------------------------------------

    lock_rr_arb #(
        .NUM_SRC   (NUM_SRC),
        .SRC_IDX_W (SRC_IDX_W)
    ) u_arb (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_upd     (send),
        .i_req     (q_not_empty),
        .i_tail    (q_tail),
        .o_gnt     (gnt),
        .o_idx     (gnt_idx),
        .o_gnt_vld (gnt_vld),
        .o_locked  ()
    );

    // flit moves when granted and downstream has room
    assign send     = gnt_vld & accept;
    // only the granted queue pops
    assign q_pop    = gnt & {NUM_SRC{send}};
    // head flit of the granted queue
    assign sel_flit = q_head_flit[gnt_idx];

    flit_out_stage #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_out (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_send     (send),
        .i_flit     (sel_flit),
        .i_crd_rtn  (i_crd_rtn),
        .o_accept   (accept),
        .o_out_vld  (o_out_vld),
        .o_out_flit (o_out_flit)
    );

endmodule : flit_port_top

// ==== flit_out_stage.sv ====
// output register with a downstream credit counter; accept is high while credit is held
module flit_out_stage #(
    parameter int OUT_CREDITS = 3
) (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_send,
    input  flit_arb_pkg::flit_t i_flit,
    input  logic                i_crd_rtn,
    output logic                o_accept,
    output logic                o_out_vld,
    output flit_arb_pkg::flit_t o_out_flit
);

    import flit_arb_pkg::*;

    // credits currently held
    crd_cnt_t q_crd_cnt;
    // a send only counts with credit in hand
    logic     send_ok;

    assign o_accept = (q_crd_cnt != '0);
    assign send_ok  = i_send & o_accept;

    // ------------------------------------------------------------------------
    // credit counter
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            q_crd_cnt <= crd_cnt_t'(OUT_CREDITS);
        end
        else
        begin
            // send and return together cancel out
            case ({send_ok, i_crd_rtn})
                2'b10:   q_crd_cnt <= q_crd_cnt - crd_cnt_t'(1);
                2'b01:   q_crd_cnt <= q_crd_cnt + crd_cnt_t'(1);
                default: q_crd_cnt <= q_crd_cnt;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // output register
    // ------------------------------------------------------------------------

    // valid follows the send by one cycle, drops when nothing is sent
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_out_vld <= 1'b0;
        end
        else
        begin
            o_out_vld <= send_ok;
        end
    end

    // payload only loads on a send
    always_ff @(posedge clk)
    begin
        if (send_ok)
        begin
            o_out_flit <= i_flit;
        end
    end

endmodule : flit_out_stage

// ==== flit_in_queue.sv ====
// per-source flit queue; pops on grant and hands one credit back to its source per pop
module flit_in_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_push,
    input  flit_arb_pkg::flit_t i_flit,
    input  logic                i_pop,
    output flit_arb_pkg::flit_t o_head,
    output logic                o_not_empty,
    output logic                o_src_crd
);

    import flit_arb_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // flit storage
    flit_t            mem [QUEUE_DEPTH];

    // circular pointers and occupancy
    logic [PTR_W-1:0] q_wr_ptr;
    logic [PTR_W-1:0] q_rd_ptr;
    logic [CNT_W-1:0] q_count;
    logic             pop_ok;

    // wrap at depth, works for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1))
        begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign o_not_empty = (q_count != '0);
    // pop on an empty queue is ignored
    assign pop_ok      = i_pop & o_not_empty;

    // ------------------------------------------------------------------------
    // pointers and count
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
        end
        else
        begin
            if (i_push)
            begin
                q_wr_ptr <= ptr_inc(q_wr_ptr);
            end
            if (pop_ok)
            begin
                q_rd_ptr <= ptr_inc(q_rd_ptr);
            end
            // push is credit limited, never overflows
            case ({i_push, pop_ok})
                2'b10:   q_count <= q_count + CNT_W'(1);
                2'b01:   q_count <= q_count - CNT_W'(1);
                default: q_count <= q_count;
            endcase
        end
    end

    // storage write
    always_ff @(posedge clk)
    begin
        if (i_push)
        begin
            mem[q_wr_ptr] <= i_flit;
        end
    end

    assign o_head    = mem[q_rd_ptr];
    // credit goes back in the pop cycle
    assign o_src_crd = pop_ok;

endmodule : flit_in_queue

// ==== lock_rr_arb.sv ====
// locking round-robin arbiter; holds one source for a whole packet, then rotates priority
module lock_rr_arb #(
    parameter int NUM_SRC   = 4,
    parameter int SRC_IDX_W = 2
) (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  logic                 i_upd,
    input  logic [NUM_SRC-1:0]   i_req,
    input  logic [NUM_SRC-1:0]   i_tail,
    output logic [NUM_SRC-1:0]   o_gnt,
    output logic [SRC_IDX_W-1:0] o_idx,
    output logic                 o_gnt_vld,
    output logic                 o_locked
);

    import flit_arb_pkg::*;

    // lock state and one-hot head register
    arb_state_e           q_state;
    arb_state_e           next_state;
    logic [NUM_SRC-1:0]   q_head;
    logic [NUM_SRC-1:0]   next_head;

    // encoder results
    logic [NUM_SRC-1:0]   enc_gnt;
    logic [SRC_IDX_W-1:0] enc_idx;
    logic                 some_req;

    // decode of the truth table
    logic                 locked;
    logic [NUM_SRC-1:0]   req_at_head_vec;
    logic                 req_at_head;
    logic                 gnt_tail;
    logic                 rotate_head;
    logic                 lock_head;
    logic                 head_en;

    var_prio_enc #(
        .NUM_SRC   (NUM_SRC),
        .SRC_IDX_W (SRC_IDX_W)
    ) u_enc (
        .i_req   (i_req),
        .i_head  (q_head),
        .o_gnt   (enc_gnt),
        .o_idx   (enc_idx),
        .o_valid (some_req)
    );

    assign locked          = (q_state == ARB_LOCKED);
    assign req_at_head_vec = i_req & q_head;
    assign req_at_head     = |req_at_head_vec;

    // granted flit is a tail
    assign gnt_tail = |(o_gnt & i_tail);

    // tail accepted, priority moves past the granted source
    assign rotate_head = i_upd & gnt_tail;

    // free with a winner that is not a finished one-flit packet
    assign lock_head = ~locked & some_req & ~rotate_head;

    // head only moves when someone asks
    assign head_en = some_req;

    // ------------------------------------------------------------------------
    // next state and head
    // ------------------------------------------------------------------------

    always_comb
    begin
        next_state = q_state;
        next_head  = q_head;
        if (rotate_head)
        begin
            // unlock, or stay free, and step one past the grant
            next_state = ARB_FREE;
            next_head  = {o_gnt[NUM_SRC-2:0], o_gnt[NUM_SRC-1]};
        end
        else if (lock_head)
        begin
            next_state = ARB_LOCKED;
            next_head  = o_gnt;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            q_state <= ARB_FREE;
            // source 0 has priority out of reset
            q_head  <= NUM_SRC'(1);
        end
        else
        begin
            q_state <= next_state;
            if (head_en)
            begin
                q_head <= next_head;
            end
        end
    end

    // while locked only the head source may be granted
    assign o_gnt     = locked ? req_at_head_vec : enc_gnt;
    assign o_gnt_vld = locked ? req_at_head : some_req;
    // encoder starts at the head, so it also names the locked source
    assign o_idx     = enc_idx;
    assign o_locked  = locked;

endmodule : lock_rr_arb

// ==== var_prio_enc.sv ====
// parallel variable-priority encoder; picks the first request at or after a one-hot head
module var_prio_enc #(
    parameter int NUM_SRC   = 4,
    parameter int SRC_IDX_W = 2
) (
    input  logic [NUM_SRC-1:0]   i_req,
    input  logic [NUM_SRC-1:0]   i_head,
    output logic [NUM_SRC-1:0]   o_gnt,
    output logic [SRC_IDX_W-1:0] o_idx,
    output logic                 o_valid
);

    // bits at and above the head position
    logic [NUM_SRC-1:0]   thermo;
    // upper copy covers the wrap, lower copy is masked by the head
    logic [2*NUM_SRC-1:0] dbl_req;
    // lowest set bit of the doubled vector
    logic [2*NUM_SRC-1:0] dbl_first;

    // one-hot minus one sets every bit below the head
    assign thermo = ~(i_head - NUM_SRC'(1));

    // requests below the head only win through the upper copy
    assign dbl_req = {i_req, i_req & thermo};

    // isolate lowest set bit, two's complement trick
    assign dbl_first = dbl_req & (~dbl_req + (2*NUM_SRC)'(1));

    // fold both halves back, only one of them can hold the winner
    assign o_gnt = dbl_first[NUM_SRC-1:0] | dbl_first[2*NUM_SRC-1:NUM_SRC];

    // any request at all means a winner exists
    assign o_valid = |i_req;

    // ------------------------------------------------------------------------
    // one-hot to binary
    // ------------------------------------------------------------------------

    always_comb
    begin
        o_idx = '0;
        // grant is one-hot, so or-ing the indices is exact
        for (int i = 0; i < NUM_SRC; i++)
        begin
            if (o_gnt[i])
            begin
                o_idx = o_idx | SRC_IDX_W'(i);
            end
        end
    end

endmodule : var_prio_enc

// ==== flit_arb_pkg.sv ====
// shared flit, width and arbiter state types; imported by every block of the flit port
package flit_arb_pkg;

    // ------------------------------------------------------------------------
    // widths that carry a meaning
    // ------------------------------------------------------------------------

    // flit payload as seen by sources and downstream
    typedef logic [15:0] payload_t;

    // downstream credit counter, holds up to 15 credits
    typedef logic [3:0] crd_cnt_t;

    // ------------------------------------------------------------------------
    // flit format
    // ------------------------------------------------------------------------

    // tail marks the last flit of a packet
    // 17 bits total, payload in the upper bits
    typedef struct packed {
        payload_t payload;
        logic     tail;
    } flit_t;

    // ------------------------------------------------------------------------
    // arbiter lock state
    // ------------------------------------------------------------------------

    // free means no packet in progress
    // locked means the head source owns the output until its tail is accepted
    typedef enum logic {
        ARB_FREE   = 1'b0,
        ARB_LOCKED = 1'b1
    } arb_state_e;

endpackage : flit_arb_pkg
